//--- include/div_settings.svh
// width settings for the iterative divider
// included by the package and by every RTL block that sizes a vector

`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// --------------------
// operand width
// --------------------
// dividend, divisor, quotient and remainder all share this width
// 16, 32 and 64 are all valid choices
`define DIV_WIDTH 32

// --------------------
// counter width
// --------------------
// log2 of the operand width plus one spare bit for the iteration counter
`define DIV_CNT_W ($clog2(`DIV_WIDTH) + 1)

`endif

//--- rtl/div_pkg.sv
// shared types for the iterative divider
// compile before any block that names a request, a response or the function code

`default_nettype none

`include "div_settings.svh"

package div_pkg;

  // --------------------
  // function code
  // --------------------
  // selects how the operands and the results are interpreted
  typedef enum logic {
    DIV_FN_UNSIGNED = 1'b0,
    DIV_FN_SIGNED   = 1'b1
  } div_fn_e;

  // --------------------
  // request payload
  // --------------------
  // 2*width + 1 bits with fn on top
  typedef struct packed {
    div_fn_e               fn;
    // dividend
    logic [`DIV_WIDTH-1:0] a;
    // divisor
    logic [`DIV_WIDTH-1:0] b;
  } div_req_t;

  // --------------------
  // response payload
  // --------------------
  // remainder in the upper half and quotient in the lower half of the word
  typedef struct packed {
    logic [`DIV_WIDTH-1:0] rem;
    logic [`DIV_WIDTH-1:0] quo;
  } div_resp_t;

endpackage

`default_nettype wire

//--- rtl/div_iter_dpath.sv
// datapath of the iterative divider
// restoring shift-subtract core with sign handling on entry and exit

`default_nettype none

`include "div_settings.svh"

module div_iter_dpath (
  input  logic               clk,
  input  logic               reset,
  // request payload, sampled when load is high
  input  div_pkg::div_req_t  req,
  // enables from the control FSM
  input  logic               load,
  input  logic               step,
  // result, valid while the FSM sits in done
  output div_pkg::div_resp_t resp
);

  import div_pkg::*;

  localparam int unsigned W = `DIV_WIDTH;

  // two's complement negation at operand width
  function automatic logic [W-1:0] negate(input logic [W-1:0] x);
    return ~x + 1'b1;
  endfunction

  // --------------------
  // operand conditioning
  // --------------------

  // an operand counts as negative only in signed mode
  logic         neg_a;
  logic         neg_b;
  // magnitudes fed into the core
  logic [W-1:0] mag_a;
  logic [W-1:0] mag_b;

  assign neg_a = (req.fn == DIV_FN_SIGNED) && req.a[W-1];
  assign neg_b = (req.fn == DIV_FN_SIGNED) && req.b[W-1];

  // most negative value maps onto itself
  // and the unsigned core still reads it as 2**(W-1)
  assign mag_a = neg_a ? negate(req.a) : req.a;
  assign mag_b = neg_b ? negate(req.b) : req.b;

  // --------------------
  // core registers
  // --------------------

  // upper half holds the partial remainder
  // lower half starts as the dividend and fills up with quotient bits
  logic [2*W-1:0] rq_q;
  // divisor magnitude, constant for the whole division
  logic [W-1:0]   dvsr_q;
  // dividend as it arrived, returned as remainder on divide by zero
  logic [W-1:0]   dvnd_q;
  // result sign flags
  logic           quo_neg_q;
  logic           rem_neg_q;
  // divisor was zero
  logic           zero_q;

  // --------------------
  // one iteration
  // --------------------

  // remainder after the shift
  // one bit wider because the top bit leaves the register
  logic [W:0]     rem_shift;
  // trial difference with one extra bit as the sign
  logic [W+1:0]   diff;
  logic           diff_neg;
  // register contents after this step
  logic [2*W-1:0] rq_step;

  assign rem_shift = rq_q[2*W-1:W-1];
  assign diff      = {1'b0, rem_shift} - {2'b00, dvsr_q};
  assign diff_neg  = diff[W+1];

  // difference fits in W bits whenever it is not negative
  // since it is then smaller than the divisor
  always_comb begin
    if (diff_neg) begin
      // restore, quotient bit is zero
      rq_step = {rq_q[2*W-2:0], 1'b0};
    end else begin
      // keep the difference, quotient bit is one
      rq_step = {diff[W-1:0], rq_q[W-2:0], 1'b1};
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rq_q      <= {{W{1'b0}}, mag_a};
      dvsr_q    <= mag_b;
      dvnd_q    <= req.a;
      // quotient is negative when exactly one operand is negative
      quo_neg_q <= neg_a ^ neg_b;
      // remainder follows the dividend
      rem_neg_q <= neg_a;
      zero_q    <= (req.b == '0);
    end else if (step) begin
      rq_q      <= rq_step;
    end
  end

  // --------------------
  // result fixup
  // --------------------

  logic [W-1:0] quo_mag;
  logic [W-1:0] rem_mag;
  logic [W-1:0] quo_fix;
  logic [W-1:0] rem_fix;

  assign quo_mag = rq_q[W-1:0];
  assign rem_mag = rq_q[2*W-1:W];

  // put the signs back
  assign quo_fix = quo_neg_q ? negate(quo_mag) : quo_mag;
  assign rem_fix = rem_neg_q ? negate(rem_mag) : rem_mag;

  // divide by zero wins over the sign fixup in both modes
  // overflow needs no special case, the core already gives 2**(W-1) and 0
  assign resp.quo = zero_q ? '1 : quo_fix;
  assign resp.rem = zero_q ? dvnd_q : rem_fix;

  // --------------------
  // checks
  // --------------------

  // control never captures new operands in the middle of an iteration
  a_load_step_excl : assert property (
    @(posedge clk) disable iff (reset)
      !(load && step)
  ) else $error("dpath load and step high together");

endmodule

`default_nettype wire

//--- rtl/div_iter_ctrl.sv
// control FSM of the iterative divider
// runs idle, calc and done and drives the handshakes and the datapath enables

`default_nettype none

`include "div_settings.svh"

module div_iter_ctrl (
  input  logic clk,
  input  logic reset,
  // request handshake
  input  logic req_val,
  output logic req_rdy,
  // response handshake
  output logic resp_val,
  input  logic resp_rdy,
  // datapath enables
  output logic load,
  output logic step
);

  localparam int unsigned      CNT_W     = `DIV_CNT_W;
  // counter value during the final step
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`DIV_WIDTH - 1);

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } state_e;

  state_e           state;
  state_e           state_next;
  // steps taken so far in calc
  logic [CNT_W-1:0] cnt;

  logic req_fire;
  logic resp_fire;
  logic last_step;

  // --------------------
  // handshake
  // --------------------

  // only one division in flight
  assign req_rdy   = (state == ST_IDLE);
  assign resp_val  = (state == ST_DONE);

  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  // --------------------
  // datapath enables
  // --------------------

  // operands are captured on the accepting edge
  assign load      = req_fire;
  // one quotient bit per calc cycle
  assign step      = (state == ST_CALC);
  assign last_step = step && (cnt == LAST_STEP);

  // --------------------
  // next state
  // --------------------

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (req_fire) begin
          state_next = ST_CALC;
        end
      end
      ST_CALC: begin
        // result is ready right after the last step edge
        if (last_step) begin
          state_next = ST_DONE;
        end
      end
      ST_DONE: begin
        // hold here under back-pressure
        if (resp_fire) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // iteration counter stops at LAST_STEP
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (req_fire) begin
      cnt <= '0;
    end else if (step && !last_step) begin
      cnt <= cnt + 1'b1;
    end
  end

  // --------------------
  // checks
  // --------------------

  // a response is never withdrawn before the consumer takes it
  a_resp_hold : assert property (
    @(posedge clk) disable iff (reset)
      resp_val && !resp_rdy |=> resp_val
  ) else $error("resp_val dropped before resp_rdy");

  a_hs_excl : assert property (
    @(posedge clk) disable iff (reset)
      !(req_rdy && resp_val)
  ) else $error("req_rdy and resp_val high together");

  a_cnt_range : assert property (
    @(posedge clk) disable iff (reset)
      (state == ST_CALC) |-> (cnt <= LAST_STEP)
  ) else $error("iteration counter out of range, cnt = %0h", cnt);

endmodule

`default_nettype wire

//--- rtl/div_iter_unit.sv
// top level of the iterative integer divider
// valid/ready request in and response out, one division in flight at a time

`default_nettype none

module div_iter_unit (
  input  logic               clk,
  input  logic               reset,

  // --------------------
  // request side
  // --------------------
  input  div_pkg::div_req_t  req,
  input  logic               req_val,
  output logic               req_rdy,

  // --------------------
  // response side
  // --------------------
  output div_pkg::div_resp_t resp,
  output logic               resp_val,
  input  logic               resp_rdy
);

  // capture operands on the accepting edge
  logic load;
  // one shift-subtract iteration
  logic step;

  // --------------------
  // control
  // --------------------

  // owns both handshakes and sequences the datapath
  div_iter_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load     (load),
    .step     (step)
  );

  // --------------------
  // datapath
  // --------------------

  // payloads go straight in and out
  // resp is meaningful only while resp_val is high
  div_iter_dpath dpath (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .load  (load),
    .step  (step),
    .resp  (resp)
  );

endmodule

`default_nettype wire

//--- verif/div_iter_tb.sv
// testbench for the iterative divider
// random and corner requests go through div_iter_unit and concurrent assertions check the results

`default_nettype none

`include "div_settings.svh"

module div_iter_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import div_pkg::*;

  localparam int          W            = `DIV_WIDTH;
  localparam logic [W-1:0] MIN_VAL     = {1'b1, {(W-1){1'b0}}};
  localparam int unsigned SEED         = 32'h4f15_b32f;
  localparam int          MAX_STALL    = 7;
  // request counts per test
  localparam int          N_UNSIGNED   = 40;
  localparam int          N_SIGNED_PER = 10;
  localparam int          N_CORNER     = 5;
  localparam int          N_LATENCY    = 8;
  localparam int          N_STALL      = 20;
  localparam int          N_BUSY       = 4;
  localparam int          TOTAL_REQS   = N_UNSIGNED + 2 + 4 * N_SIGNED_PER + N_CORNER
                                         + N_LATENCY + N_STALL + 2 * N_BUSY;
  // margin of 2 over the slowest possible request
  localparam int          TIMEOUT_CYCLES = 2 * TOTAL_REQS * (W + 2 + MAX_STALL);

  logic      clk;
  logic      reset;
  div_req_t  req;
  logic      req_val;
  logic      req_rdy;
  div_resp_t resp;
  logic      resp_val;
  logic      resp_rdy;

  // request captured on the accepting edge and its expected result
  div_req_t  acc_req;
  div_resp_t exp_resp;
  // a division is in flight
  logic      busy;

  int errors;
  int tests_pass;
  int tests_fail;
  int cycles;

  div_iter_unit UUT (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // reference model
  // --------------------

  // truncating division where the remainder keeps the sign of the dividend
  function automatic div_resp_t div_model(input div_req_t r);
    div_resp_t           res;
    logic signed [W-1:0] sa;
    logic signed [W-1:0] sb;
    sa = r.a;
    sb = r.b;
    if (r.b == '0) begin
      // divide by zero in either mode
      res.quo = '1;
      res.rem = r.a;
    end else if (r.fn == DIV_FN_UNSIGNED) begin
      res.quo = r.a / r.b;
      res.rem = r.a % r.b;
    end else if (r.a == MIN_VAL && r.b == '1) begin
      // signed overflow wraps to the most negative value
      res.quo = MIN_VAL;
      res.rem = '0;
    end else begin
      res.quo = sa / sb;
      res.rem = sa % sb;
    end
    return res;
  endfunction

  assign exp_resp = div_model(acc_req);

  // record the request and track the busy window
  always @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (req_val && req_rdy) begin
      acc_req <= req;
      busy    <= 1'b1;
    end else if (resp_val && resp_rdy) begin
      busy    <= 1'b0;
    end
  end

  // --------------------
  // checks
  // --------------------

  a_result : assert property (
    @(posedge clk) disable iff (reset)
      (resp_val && resp_rdy) |-> (resp == exp_resp)
  ) else begin
    errors++;
    $display("Error: resp.quo = %h expected %h, resp.rem = %h expected %h",
             $sampled(resp.quo), $sampled(exp_resp.quo),
             $sampled(resp.rem), $sampled(exp_resp.rem));
  end

  // low for W samples after the accepting edge and high on the next
  a_latency : assert property (
    @(posedge clk) disable iff (reset)
      (req_val && req_rdy) |=> (!resp_val) [*W] ##1 resp_val
  ) else begin
    errors++;
    $display("Error: resp_val = %h, not rising %0d cycles after acceptance",
             $sampled(resp_val), W);
  end

  a_stable : assert property (
    @(posedge clk) disable iff (reset)
      (resp_val && !resp_rdy) |=> (resp_val && $stable(resp))
  ) else begin
    errors++;
    $display("Error: resp = %h, resp_val = %h changed while resp_rdy was low",
             $sampled(resp), $sampled(resp_val));
  end

  a_busy : assert property (
    @(posedge clk) disable iff (reset)
      busy |-> !req_rdy
  ) else begin
    errors++;
    $display("Error: req_rdy = %h while a division was in flight", $sampled(req_rdy));
  end

  // first sample after reset drops
  a_reset_state : assert property (
    @(posedge clk) $fell(reset) |-> (req_rdy && !resp_val)
  ) else begin
    errors++;
    $display("Error: after reset req_rdy = %h, resp_val = %h",
             $sampled(req_rdy), $sampled(resp_val));
  end

  // --------------------
  // stimulus helpers
  // --------------------

  function automatic logic [W-1:0] rand_word();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[W-1:0];
  endfunction

  // nonzero divisor spread over all magnitudes
  function automatic logic [W-1:0] rand_divisor();
    logic [W-1:0] d;
    d = rand_word() >> ($urandom % W);
    if (d == '0) begin
      d = 1;
    end
    return d;
  endfunction

  task automatic present_req(input div_fn_e fn, input logic [W-1:0] a, input logic [W-1:0] b);
    @(negedge clk);
    req.fn  = fn;
    req.a   = a;
    req.b   = b;
    req_val = 1'b1;
  endtask

  // req_rdy is settled at the falling edge, so the next rising edge accepts
  task automatic wait_accept();
    while (!req_rdy) begin
      @(negedge clk);
    end
    @(negedge clk);
    req_val = 1'b0;
  endtask

  // stall resp_rdy for the given cycles once resp_val is up
  task automatic take_resp(input int stall);
    while (!resp_val) begin
      @(negedge clk);
    end
    repeat (stall) @(negedge clk);
    resp_rdy = 1'b1;
    @(negedge clk);
    resp_rdy = 1'b0;
  endtask

  task automatic run_div(input div_fn_e fn, input logic [W-1:0] a, input logic [W-1:0] b,
                         input int stall);
    present_req(fn, a, b);
    wait_accept();
    take_resp(stall);
  endtask

  task automatic report_test(input string name, input int n_req, input int err_start);
    if (errors == err_start) begin
      tests_pass++;
      $display("test %s: %0d requests, ok", name, n_req);
    end else begin
      tests_fail++;
      $display("test %s: %0d requests, %0d errors", name, n_req, errors - err_start);
    end
  endtask

  // --------------------
  // timeout
  // --------------------

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, a handshake never completed", cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // --------------------
  // test sequence
  // --------------------

  initial begin
    int           err0;
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [W-1:0] mag_a;
    logic [W-1:0] mag_b;
    div_fn_e      fn;
    void'($urandom(SEED));
    errors     = 0;
    tests_pass = 0;
    tests_fail = 0;
    reset      = 1'b1;
    req        = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    err0  = errors;
    reset = 1'b0;
    @(negedge clk);
    report_test("reset state", 0, err0);

    err0 = errors;
    for (int i = 0; i < N_UNSIGNED; i++) begin
      run_div(DIV_FN_UNSIGNED, rand_word(), rand_divisor(), 0);
    end
    run_div(DIV_FN_UNSIGNED, '1, 1, 0);
    // divisor larger than the dividend
    run_div(DIV_FN_UNSIGNED, 'h1234, '1, 0);
    report_test("unsigned", N_UNSIGNED + 2, err0);

    // bit 1 of s negates the dividend and bit 0 the divisor
    err0 = errors;
    for (int s = 0; s < 4; s++) begin
      for (int i = 0; i < N_SIGNED_PER; i++) begin
        mag_a = rand_word() >> 1;
        mag_b = rand_divisor() >> 1;
        if (mag_b == '0) begin
          mag_b = 1;
        end
        a = s[1] ? -mag_a : mag_a;
        b = s[0] ? -mag_b : mag_b;
        run_div(DIV_FN_SIGNED, a, b, 0);
      end
    end
    report_test("signed", 4 * N_SIGNED_PER, err0);

    err0 = errors;
    run_div(DIV_FN_UNSIGNED, rand_word(), '0, 0);
    run_div(DIV_FN_SIGNED, MIN_VAL | rand_word(), '0, 0);
    run_div(DIV_FN_SIGNED, rand_word() >> 1, '0, 0);
    run_div(DIV_FN_SIGNED, MIN_VAL, '1, 0);
    run_div(DIV_FN_UNSIGNED, MIN_VAL, '1, 0);
    report_test("corner cases", N_CORNER, err0);

    // back to back without stalls
    err0 = errors;
    for (int i = 0; i < N_LATENCY; i++) begin
      run_div(DIV_FN_UNSIGNED, rand_word(), rand_divisor(), 0);
    end
    report_test("latency", N_LATENCY, err0);

    err0 = errors;
    for (int i = 0; i < N_STALL; i++) begin
      fn = ($urandom % 2 == 0) ? DIV_FN_UNSIGNED : DIV_FN_SIGNED;
      run_div(fn, rand_word(), rand_divisor(), $urandom % (MAX_STALL + 1));
    end
    // second request held valid through the first one's busy window
    for (int i = 0; i < N_BUSY; i++) begin
      present_req(DIV_FN_SIGNED, rand_word(), rand_divisor());
      wait_accept();
      present_req(DIV_FN_UNSIGNED, rand_word(), rand_divisor());
      take_resp($urandom % (MAX_STALL + 1));
      wait_accept();
      take_resp($urandom % (MAX_STALL + 1));
    end
    report_test("back-pressure", N_STALL + 2 * N_BUSY, err0);

    $display("tests passed %0d, failed %0d, assertion errors %0d",
             tests_pass, tests_fail, errors);
    if (tests_fail == 0 && errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
rtl/div_pkg.sv
rtl/div_iter_dpath.sv
rtl/div_iter_ctrl.sv
rtl/div_iter_unit.sv
verif/div_iter_tb.sv

//--- Bender.yml
package:
  name: div_iter

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/div_pkg.sv
      - rtl/div_iter_dpath.sv
      - rtl/div_iter_ctrl.sv
      - rtl/div_iter_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/div_iter_tb.sv
